// File: all.f
src/rvIsaPkg.sv
src/rvCtrlPkg.sv
src/controlFsm.sv
src/aluUnit.sv
src/regFile.sv
src/coreDatapath.sv
src/coreTop.sv
dv/coreBus_checker.sv
dv/coreTb.sv

// File: dv/coreBus_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and control checks, bound into the core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coreBus_checker (
  input logic                clk,
  input logic                reset,
  input logic                wrStrobe,
  input rvIsaPkg::wordT      adr,
  input rvCtrlPkg::fsmStateT state
);
  import rvCtrlPkg::*;

  int unsigned errCount = 0;

  wrOnlyInStore: assert property (@(posedge clk) disable iff (reset)
    wrStrobe |-> state == memWrite)
    else begin
      errCount++;
      $error("write strobe high outside the memory write state");
    end

  fetchAligned: assert property (@(posedge clk) disable iff (reset)
    state == fetch |-> adr[1:0] == 2'b00)
    else begin
      errCount++;
      $error("instruction fetch from an address that is not word aligned");
    end

  // every fetch hands over to decode
  fetchThenDecode: assert property (@(posedge clk) disable iff (reset)
    state == fetch |=> state == decode)
    else begin
      errCount++;
      $error("fetch was not followed by decode");
    end

  noWriteInReset: assert property (@(posedge clk) reset |-> !wrStrobe)
    else begin
      errCount++;
      $error("write strobe high while reset is asserted");
    end

endmodule

bind coreTop coreBus_checker chk0 (
  .clk(clk), .reset(reset), .wrStrobe(memWrite), .adr(memAdr), .state(fsmState)
);

// File: dv/coreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the RV32I multicycle core with its memory
// model and a self-checking program image
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coreTb;
  import rvIsaPkg::*;
  import rvCtrlPkg::*;

  logic     clk;
  logic     reset;
  wordT     busRdata;
  wordT     busAdr;
  wordT     busWdata;
  logic     busWrite;
  fsmStateT state;

  wordT mem [256];
  wordT expAdr [$];
  wordT expData [$];
  wordT opA;          // LCG data words 0, 1 and 2
  wordT opB;
  wordT opC;
  wordT endAdr;       // address of the final self jump
  wordT curInstr;     // last fetched instruction
  int   pcIdx;
  int   slot;         // next store offset in the result area
  int   dynCount;
  int   storeCount;
  int   cycles;
  int   timeoutLimit;

  coreTop dut0 (
    .clk(clk), .reset(reset), .memRdata(busRdata), .memAdr(busAdr),
    .memWdata(busWdata), .memWrite(busWrite), .fsmState(state)
  );

  function automatic wordT lcgNext(input wordT s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic wordT sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic wordT encR(input logic [6:0] f7, input regAdrT rs2, input regAdrT rs1,
                                input logic [2:0] f3, input regAdrT rd);
    return {f7, rs2, rs1, f3, rd, rType};
  endfunction

  function automatic wordT encI(input logic [11:0] imm, input regAdrT rs1, input logic [2:0] f3,
                                input regAdrT rd, input opcodeT op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic wordT encS(input logic [11:0] imm, input regAdrT rs2, input regAdrT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], sType};
  endfunction

  function automatic wordT encB(input logic [12:0] imm, input regAdrT rs2, input regAdrT rs1,
                                input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], bType};
  endfunction

  function automatic wordT encU(input logic [19:0] imm, input regAdrT rd, input opcodeT op);
    return {imm, rd, op};
  endfunction

  function automatic wordT encJ(input logic [20:0] imm, input regAdrT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jType};
  endfunction

  // branch outcome by the RV32I compare rules
  function automatic logic takenFor(input logic [2:0] f3, input wordT a, input wordT b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic emit(input wordT word, input logic runs);
    mem[pcIdx] = word;
    pcIdx++;
    if (runs) dynCount++;
  endtask

  task automatic storeExpect(input regAdrT rs2, input wordT value);
    emit(encS(12'(slot * 4), rs2, 5'd2), 1'b1);
    expAdr.push_back(32'h300 + slot * 4);
    expData.push_back(value);
    slot++;
  endtask

  task automatic storeSkipped(input regAdrT rs2); // must never execute
    emit(encS(12'(slot * 4), rs2, 5'd2), 1'b0);
    slot++;
  endtask

  task automatic aluCase(input wordT instr, input wordT expected);
    emit(instr, 1'b1); // result lands in x5
    storeExpect(5'd5, expected);
  endtask

  task automatic branchCase(input logic [2:0] f3, input regAdrT rs1, input regAdrT rs2);
    wordT a;
    wordT b;
    a = (rs1 == 5'd8) ? '1 : 32'd1; // x8 holds -1 and x9 holds 1
    b = (rs2 == 5'd8) ? '1 : 32'd1;
    emit(encB(13'd8, rs2, rs1, f3), 1'b1);
    if (takenFor(f3, a, b)) storeSkipped(5'd3);
    else storeExpect(5'd3, opA);
  endtask

  task automatic buildProgram();
    wordT seed;
    wordT adrNow;
    seed = 32'd52;
    for (int i = 0; i < 256; i++) begin
      seed = lcgNext(seed);
      mem[i] = seed;
    end
    opA = mem[128];
    opB = mem[129];
    opC = mem[130];
    pcIdx = 0;
    slot = 0;
    dynCount = 0;
    emit(encI(12'h200, 5'd0, 3'b000, 5'd1, iTypeLogic), 1'b1); // x1 data base
    emit(encI(12'h300, 5'd0, 3'b000, 5'd2, iTypeLogic), 1'b1); // x2 result base
    emit(encI(12'h000, 5'd1, 3'b010, 5'd3, iTypeLoad), 1'b1);
    emit(encI(12'h004, 5'd1, 3'b010, 5'd4, iTypeLoad), 1'b1);
    emit(encI(12'hFFF, 5'd0, 3'b000, 5'd8, iTypeLogic), 1'b1);
    emit(encI(12'h001, 5'd0, 3'b000, 5'd9, iTypeLogic), 1'b1);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b000, 5'd5), opA + opB);
    aluCase(encR(7'h20, 5'd4, 5'd3, 3'b000, 5'd5), opA - opB);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b001, 5'd5), opA << opB[4:0]);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b010, 5'd5), {31'b0, $signed(opA) < $signed(opB)});
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b011, 5'd5), {31'b0, opA < opB});
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b100, 5'd5), opA ^ opB);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b101, 5'd5), opA >> opB[4:0]);
    aluCase(encR(7'h20, 5'd4, 5'd3, 3'b101, 5'd5), $signed(opA) >>> opB[4:0]);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b110, 5'd5), opA | opB);
    aluCase(encR(7'h00, 5'd4, 5'd3, 3'b111, 5'd5), opA & opB);
    aluCase(encI(12'hEDD, 5'd3, 3'b000, 5'd5, iTypeLogic), opA + sext12(12'hEDD));
    aluCase(encI(12'h7F0, 5'd3, 3'b010, 5'd5, iTypeLogic),
            {31'b0, $signed(opA) < $signed(sext12(12'h7F0))});
    aluCase(encI(12'hF00, 5'd3, 3'b011, 5'd5, iTypeLogic), {31'b0, opA < sext12(12'hF00)});
    aluCase(encI(12'h5A5, 5'd3, 3'b100, 5'd5, iTypeLogic), opA ^ sext12(12'h5A5));
    aluCase(encI(12'h0F0, 5'd3, 3'b110, 5'd5, iTypeLogic), opA | sext12(12'h0F0));
    aluCase(encI(12'hF0F, 5'd3, 3'b111, 5'd5, iTypeLogic), opA & sext12(12'hF0F));
    aluCase(encI(12'h007, 5'd3, 3'b001, 5'd5, iTypeLogic), opA << 7);
    aluCase(encI(12'h00D, 5'd3, 3'b101, 5'd5, iTypeLogic), opA >> 13);
    aluCase(encI(12'h413, 5'd3, 3'b101, 5'd5, iTypeLogic), $signed(opA) >>> 19); // srai 19
    aluCase(encU(20'hABCDE, 5'd5, uTypeLui), 32'hABCDE000);
    adrNow = pcIdx * 4;
    aluCase(encU(20'h12345, 5'd5, uTypeAuipc), adrNow + 32'h12345000);
    emit(encI(12'h008, 5'd1, 3'b010, 5'd6, iTypeLoad), 1'b1); // copy data word 2
    storeExpect(5'd6, opC);
    branchCase(beq, 5'd9, 5'd9);
    branchCase(beq, 5'd9, 5'd8);
    branchCase(bne, 5'd9, 5'd8);
    branchCase(bne, 5'd9, 5'd9);
    branchCase(blt, 5'd8, 5'd9);
    branchCase(blt, 5'd9, 5'd8);
    branchCase(bge, 5'd9, 5'd8);
    branchCase(bge, 5'd8, 5'd9);
    branchCase(bltu, 5'd9, 5'd8);
    branchCase(bltu, 5'd8, 5'd9);
    branchCase(bgeu, 5'd8, 5'd9);
    branchCase(bgeu, 5'd9, 5'd8);
    adrNow = pcIdx * 4;
    emit(encJ(21'd8, 5'd10), 1'b1); // jal over one store
    storeSkipped(5'd3);
    storeExpect(5'd10, adrNow + 4);
    adrNow = pcIdx * 4;
    emit(encI(12'(adrNow + 12), 5'd0, 3'b000, 5'd11, iTypeLogic), 1'b1);
    emit(encI(12'h001, 5'd11, 3'b000, 5'd12, iTypeJalr), 1'b1); // odd target loses bit 0
    storeSkipped(5'd3);
    storeExpect(5'd12, adrNow + 8);
    endAdr = pcIdx * 4;
    emit(encJ(21'd0, 5'd0), 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    busRdata = '0;
    storeCount = 0;
    cycles = 0;
    buildProgram();
    timeoutLimit = 5 * dynCount + 50;
    repeat (8) @(negedge clk);
    reset <= 1'b0;
    curInstr = mem[busAdr[9:2]]; // first fetch is already on the bus as reset drops
    assert (state == fetch && busAdr == '0)
      else failRun($sformatf("mismatch at %0t: first fetch from %h instead of address 0",
                             $time, busAdr));
  end

  // read data follows the address at each falling edge
  always @(negedge clk) begin
    busRdata <= mem[busAdr[9:2]];
  end

  always @(posedge clk) begin
    if (!reset && busWrite) mem[busAdr[9:2]] <= busWdata;
  end

  always @(negedge clk) begin
    if (!reset) begin
      cycles++;
      assert (cycles <= timeoutLimit)
        else failRun($sformatf("timeout after %0d cycles, final jump never fetched", cycles));
      assert (dut0.chk0.errCount == 0) else failRun("a bus checker assertion failed");
      if (state == fetch) curInstr = mem[busAdr[9:2]];
      if (busWrite) begin
        assert (curInstr[6:0] == sType) else failRun("memory write by a non-store instruction");
        assert (storeCount < expAdr.size() && busAdr == expAdr[storeCount]
                && busWdata == expData[storeCount]) storeCount++;
          else failRun($sformatf("mismatch at %0t: store %0d wrote %h to %h", $time,
                                 storeCount, busWdata, busAdr));
      end
      if (state == fetch && busAdr == endAdr) begin
        if (storeCount == expAdr.size()) begin
          $display("ALL TESTS PASSED");
          $finish;
        end else begin
          failRun($sformatf("program ended after %0d of %0d stores", storeCount,
                            expAdr.size()));
        end
      end
    end
  end

endmodule

// File: src/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU operation decoder and 32-bit ALU with zero flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aluUnit (
  input  rvIsaPkg::instrFieldsT fields,
  input  rvCtrlPkg::aluOpT      aluOp,
  input  rvIsaPkg::wordT        a,
  input  rvIsaPkg::wordT        b,
  output rvIsaPkg::wordT        result,
  output logic                  zero
);
  import rvIsaPkg::*;
  import rvCtrlPkg::*;

  typedef enum logic [3:0] {
    fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSll, fnSrl, fnSra, fnSlt, fnSltu
  } aluFnT;

  aluFnT fn;
  logic  invert; // bge and bgeu take the negated compare
  wordT  raw;

  always_comb begin
    fn     = fnAdd;
    invert = 1'b0;
    case (aluOp)
      branch: begin
        case (branchF3T'(fields.funct3))
          beq, bne: fn = fnSub;
          blt:      fn = fnSlt;
          bltu:     fn = fnSltu;
          bge: begin
            fn     = fnSlt;
            invert = 1'b1;
          end
          bgeu: begin
            fn     = fnSltu;
            invert = 1'b1;
          end
          default:  fn = fnSub;
        endcase
      end
      rFunct, iFunct: begin
        case (fields.funct3)
          3'b000: fn = (aluOp == rFunct && fields.funct7[5]) ? fnSub : fnAdd;
          3'b001: fn = fnSll;
          3'b010: fn = fnSlt;
          3'b011: fn = fnSltu;
          3'b100: fn = fnXor;
          3'b101: fn = fields.funct7[5] ? fnSra : fnSrl; // srai keeps bit 30 too
          3'b110: fn = fnOr;
          default: fn = fnAnd;
        endcase
      end
      default: fn = fnAdd;
    endcase
  end

  always_comb begin
    case (fn)
      fnSub:   raw = a - b;
      fnAnd:   raw = a & b;
      fnOr:    raw = a | b;
      fnXor:   raw = a ^ b;
      fnSll:   raw = a << b[4:0];
      fnSrl:   raw = a >> b[4:0];
      fnSra:   raw = wordT'($signed(a) >>> b[4:0]);
      fnSlt:   raw = wordT'($signed(a) < $signed(b));
      fnSltu:  raw = wordT'(a < b);
      default: raw = a + b;
    endcase
  end

  assign result = invert ? wordT'(!raw[0]) : raw;
  assign zero   = (result == '0);

endmodule

// File: src/controlFsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Moore control FSM sequencing one RV32I instruction at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module controlFsm (
  input  logic                  clk,
  input  logic                  reset,
  input  rvIsaPkg::instrFieldsT fields,
  input  logic                  zero,
  input  rvIsaPkg::wordT        aluResult,
  output rvCtrlPkg::ctrlWordT   ctrl,
  output rvCtrlPkg::fsmStateT   state
);
  import rvIsaPkg::*;
  import rvCtrlPkg::*;

  fsmStateT curState;
  fsmStateT nextState;
  logic     branchTaken;

  assign state = curState;

  always_comb begin
    nextState = fetch;
    case (curState)
      fetch: nextState = decode;
      decode: begin
        case (fields.opcode)
          rType:      nextState = executeR;
          iTypeLogic: nextState = executeI;
          iTypeLoad,
          sType:      nextState = memAdr;
          jType:      nextState = uncondJump;
          iTypeJalr:  nextState = jalrCalc;
          uTypeLui:   nextState = lui;
          uTypeAuipc: nextState = auipc;
          bType: begin
            case (branchF3T'(fields.funct3))
              beq:     nextState = branchEq;
              bne:     nextState = branchNe;
              default: nextState = branchCmp;
            endcase
          end
          default:    nextState = fetch; // unknown opcode, skip it
        endcase
      end
      memAdr: begin
        if (fields.opcode == iTypeLoad) nextState = memRead;
        else if (fields.opcode == sType) nextState = memWrite;
        else nextState = fetch;
      end
      memRead:  nextState = memWb;
      jalrCalc: nextState = jalrLink;
      executeR,
      executeI,
      uncondJump,
      lui,
      auipc,
      jalrLink: nextState = aluWb;
      default:  nextState = fetch;  // memWrite, memWb, aluWb and branches
    endcase
  end

  // branch condition from the ALU in the resolve state
  always_comb begin
    case (curState)
      branchEq:  branchTaken = zero;
      branchNe:  branchTaken = !zero;
      branchCmp: branchTaken = (aluResult == wordT'(1));
      default:   branchTaken = 1'b0;
    endcase
  end

  always_comb begin
    ctrl.adrSrc    = adrPc;
    ctrl.aluSrcA   = srcAOldPc;
    ctrl.aluSrcB   = srcBImm;
    ctrl.resultSrc = resAluOut;
    ctrl.pcSrc     = pcIncr;
    ctrl.aluOp     = add;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    case (curState)
      fetch: begin
        ctrl.aluSrcA  = srcAPc;   // pc + 4 on the ALU
        ctrl.aluSrcB  = srcBFour;
        ctrl.irWrite  = 1'b1;
        ctrl.pcUpdate = 1'b1;
      end
      executeR: begin
        ctrl.aluSrcA = srcARs1;
        ctrl.aluSrcB = srcBRs2;
        ctrl.aluOp   = rFunct;
      end
      executeI: begin
        ctrl.aluSrcA = srcARs1;
        ctrl.aluOp   = iFunct;
      end
      uncondJump: begin
        ctrl.aluSrcB  = srcBFour; // link value, target already in aluOut
        ctrl.pcSrc    = pcJump;
        ctrl.pcUpdate = 1'b1;
      end
      memAdr:   ctrl.aluSrcA = srcARs1;
      jalrCalc: ctrl.aluSrcA = srcARs1;
      memRead:  ctrl.adrSrc = adrResult;
      memWrite: begin
        ctrl.adrSrc   = adrResult;
        ctrl.memWrite = 1'b1;
      end
      memWb: begin
        ctrl.resultSrc = resData;
        ctrl.regWrite  = 1'b1;
      end
      aluWb: ctrl.regWrite = 1'b1;
      branchEq,
      branchNe,
      branchCmp: begin
        ctrl.aluSrcA  = srcARs1;
        ctrl.aluSrcB  = srcBRs2;
        ctrl.aluOp    = branch;
        ctrl.branch   = 1'b1;
        ctrl.pcSrc    = branchTaken ? pcJump : pcIncr;
        ctrl.pcUpdate = branchTaken;
      end
      lui:   ctrl.aluSrcA = srcAZero; // 0 + upper immediate
      auipc: ctrl.aluSrcA = srcAOldPc;
      jalrLink: begin
        ctrl.aluSrcB  = srcBFour;
        ctrl.pcSrc    = pcAluResult;  // rs1 + imm from jalrCalc
        ctrl.pcUpdate = 1'b1;
      end
      default: ctrl.aluOp = add; // decode computes old pc + imm
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      curState <= fetch;
    end else begin
      curState <= nextState;
    end
  end

endmodule

// File: src/coreDatapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multicycle datapath: PC, staging registers, immediates, muxes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coreDatapath (
  input  logic                  clk,
  input  logic                  reset,
  input  rvCtrlPkg::ctrlWordT   ctrl,
  input  rvIsaPkg::wordT        memRdata,
  input  rvIsaPkg::wordT        rd1,
  input  rvIsaPkg::wordT        rd2,
  input  rvIsaPkg::wordT        aluResult,
  output rvIsaPkg::instrFieldsT fields,
  output rvIsaPkg::wordT        aluA,
  output rvIsaPkg::wordT        aluB,
  output rvIsaPkg::wordT        result,
  output rvIsaPkg::wordT        memAdr,
  output rvIsaPkg::wordT        memWdata,
  output rvIsaPkg::regAdrT      ra1,
  output rvIsaPkg::regAdrT      ra2,
  output rvIsaPkg::regAdrT      wa
);
  import rvIsaPkg::*;
  import rvCtrlPkg::*;

  wordT pc;
  wordT oldPc;   // address of the instruction in flight
  wordT instr;
  wordT dataReg;
  wordT aluOut;
  wordT immExt;
  wordT pcNext;

  assign fields = instrFieldsT'(instr);
  assign ra1    = fields.rs1;
  assign ra2    = fields.rs2;
  assign wa     = fields.rd;

  // immediate format follows the opcode in the instruction register
  always_comb begin
    case (fields.opcode)
      iTypeLogic, iTypeLoad, iTypeJalr:
        immExt = {{20{instr[31]}}, instr[31:20]};
      sType:
        immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      bType:
        immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      jType:
        immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      uTypeLui, uTypeAuipc:
        immExt = {instr[31:12], 12'b0};
      default:
        immExt = '0;
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcA)
      srcAPc:    aluA = pc;
      srcAOldPc: aluA = oldPc;
      srcARs1:   aluA = rd1;
      default:   aluA = '0;
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcB)
      srcBRs2: aluB = rd2;
      srcBImm: aluB = immExt;
      default: aluB = wordT'(4);
    endcase
  end

  always_comb begin
    case (ctrl.resultSrc)
      resData:      result = dataReg;
      resAluResult: result = aluResult;
      default:      result = aluOut;
    endcase
  end

  always_comb begin
    case (ctrl.pcSrc)
      pcJump:      pcNext = aluOut;                   // branch or jal target
      pcAluResult: pcNext = {aluOut[XLEN-1:1], 1'b0}; // jalr clears bit 0
      default:     pcNext = aluResult;                // pc + 4 from fetch
    endcase
  end

  assign memAdr   = (ctrl.adrSrc == adrPc) ? pc : result;
  assign memWdata = rd2;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.pcUpdate) begin
      pc <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      instr <= memRdata;
      oldPc <= pc;
    end
    dataReg <= memRdata;  // holds the load word after memRead
    aluOut  <= aluResult;
  end

endmodule

// File: src/coreTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I multicycle core top, single memory bus for code and data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coreTop (
  input  logic                clk,
  input  logic                reset,
  input  rvIsaPkg::wordT      memRdata,
  output rvIsaPkg::wordT      memAdr,
  output rvIsaPkg::wordT      memWdata,
  output logic                memWrite,
  output rvCtrlPkg::fsmStateT fsmState
);
  import rvIsaPkg::*;
  import rvCtrlPkg::*;

  ctrlWordT    ctrl;
  instrFieldsT fields;
  wordT        rd1;
  wordT        rd2;
  wordT        aluA;
  wordT        aluB;
  wordT        aluResult;
  wordT        result;
  regAdrT      ra1;
  regAdrT      ra2;
  regAdrT      wa;
  logic        zero;

  assign memWrite = ctrl.memWrite;

  controlFsm ctrl0 (
    .clk(clk), .reset(reset), .fields(fields), .zero(zero),
    .aluResult(aluResult), .ctrl(ctrl), .state(fsmState)
  );

  coreDatapath dp0 (
    .clk(clk), .reset(reset), .ctrl(ctrl), .memRdata(memRdata),
    .rd1(rd1), .rd2(rd2), .aluResult(aluResult), .fields(fields),
    .aluA(aluA), .aluB(aluB), .result(result), .memAdr(memAdr),
    .memWdata(memWdata), .ra1(ra1), .ra2(ra2), .wa(wa)
  );

  regFile rf0 (
    .clk(clk), .ra1(ra1), .ra2(ra2), .wa(wa), .we(ctrl.regWrite),
    .wd(result), .rd1(rd1), .rd2(rd2)
  );

  aluUnit alu0 (
    .fields(fields), .aluOp(ctrl.aluOp), .a(aluA), .b(aluB),
    .result(aluResult), .zero(zero)
  );

endmodule

// File: src/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32x32 register file, two async reads, one sync write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  rvIsaPkg::regAdrT ra1,
  input  rvIsaPkg::regAdrT ra2,
  input  rvIsaPkg::regAdrT wa,
  input  logic             we,
  input  rvIsaPkg::wordT   wd,
  output rvIsaPkg::wordT   rd1,
  output rvIsaPkg::wordT   rd2
);
  import rvIsaPkg::*;

  wordT regs [32];

  // x0 reads as zero whatever the array holds
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

endmodule

// File: src/rvCtrlPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control definitions: FSM states, mux selects, control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rvCtrlPkg;

  typedef enum logic [4:0] {
    fetch,
    decode,
    executeR,
    executeI,
    uncondJump,
    memAdr,
    memRead,
    memWrite,
    memWb,
    aluWb,
    branchEq,
    branchNe,
    branchCmp,
    lui,
    auipc,
    jalrCalc,
    jalrLink
  } fsmStateT;

  typedef enum logic {adrPc, adrResult} adrSrcT; // memory address source

  typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARs1, srcAZero} aluSrcAT;

  typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} aluSrcBT;

  typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSrcT;

  // increment uses the live ALU sum, jump and aluResult the latched one
  typedef enum logic [1:0] {pcIncr, pcJump, pcAluResult} pcSrcT;

  typedef enum logic [1:0] {add, branch, rFunct, iFunct} aluOpT;

  typedef struct packed {
    adrSrcT    adrSrc;
    aluSrcAT   aluSrcA;
    aluSrcBT   aluSrcB;
    resultSrcT resultSrc;
    pcSrcT     pcSrc;
    aluOpT     aluOp;
    logic      irWrite;
    logic      regWrite;
    logic      pcUpdate;
    logic      memWrite;
    logic      branch;   // high in the branch resolve states
  } ctrlWordT;

endpackage

// File: src/rvIsaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction set definitions: word types, opcodes,
// branch function codes and the decoded instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rvIsaPkg;

  localparam int unsigned XLEN = 32; // data width

  typedef logic [XLEN-1:0] wordT;
  typedef logic [4:0] regAdrT;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    rType      = 7'b0110011,
    iTypeLogic = 7'b0010011,
    iTypeLoad  = 7'b0000011,
    sType      = 7'b0100011,
    bType      = 7'b1100011,
    jType      = 7'b1101111,
    iTypeJalr  = 7'b1100111,
    uTypeLui   = 7'b0110111,
    uTypeAuipc = 7'b0010111
  } opcodeT;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branchF3T;

  // member order follows the instruction bit layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    regAdrT     rs2;
    regAdrT     rs1;
    logic [2:0] funct3;
    regAdrT     rd;
    opcodeT     opcode;
  } instrFieldsT;

endpackage
